//--- project.f
src/bridge_pkg.sv
src/eclk_timer.sv
src/bus_latch.sv
src/host_arbiter.sv
src/bus_cycle_fsm.sv
src/cpu_bridge.sv
tb/cpu_bridge_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
	  --top-module cpu_bridge_tb -Mdir obj_dir
	./obj_dir/Vcpu_bridge_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "test: FAIL, no result"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf obj_dir $(LOG)

//--- tb/cpu_bridge_tb.sv
// cpu bridge testbench
module cpu_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam int DTACK_LIMIT    = 2 * int'(ECLK_PHASES) * 4; // two e periods, in clk
  localparam int CYCLE_WORST    = DTACK_LIMIT + 16;      // grant wait, strobe, idle gap
  // ten bus cycles, two 40 clk stalls, halt changes, doubled
  localparam int TIMEOUT_CYCLES = 2 * (10 * CYCLE_WORST + 2 * 40 + 40);

  logic        clk = 1'b0;
  logic        _as_and_cs;
  cpu_req_t    cpu;
  host_req_t   host;
  logic        cpu_halt;
  logic        vpa;
  logic        dbr;
  logic        dbs;
  logic        nrdy;
  logic [15:0] data_in;
  int_bus_t    bus;
  logic        dtack_n;
  logic [15:0] rdata;
  logic        eclk;
  logic [15:0] host_rdat;
  logic        host_ack;

  logic [15:0] lfsr     = 16'hFAF0; // seed 64240
  int          checks   = 0;
  int          errors   = 0;        // wrong values
  int          failures = 0;        // missing handshakes
  int          cycles   = 0;

  cpu_bridge dut (.*);

  always #20 clk = ~clk; // 40 ns period

  // --------------------
  // random source

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]}; // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // --------------------
  // compare tasks

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bus(input string name, input int_bus_t got, input int_bus_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // --------------------
  // bus cycle helpers

  task automatic wait_dtack(output bit acked);
    int n;
    n     = 0;
    acked = 1'b0;
    while (!acked && n < DTACK_LIMIT) begin
      @(negedge clk);
      acked = !dtack_n;
      n++;
    end
    if (!acked) begin
      failures++;
      $display("dtack_n did not fall within %0d clk at %0t", DTACK_LIMIT, $time);
    end
  endtask

  // strobe 2 clk after the fall, 4 clk long, read data valid at 6
  task automatic follow_strobe(input int_bus_t exp);
    int_bus_t e;
    for (int k = 1; k <= 6; k++) begin
      @(negedge clk);
      e = exp;
      if (k < 2 || k > 5) begin
        e.rd  = 1'b0;
        e.hwr = 1'b0;
        e.lwr = 1'b0;
      end
      check_bus("bus", bus, e);
      check_bit("dtack_n", dtack_n, 1'b0); // held while as_n stays low
    end
  endtask

  task automatic drive_request(input bit from_host, input logic is_read,
                               input logic [1:0] lanes,
                               output int_bus_t exp, output logic [15:0] word);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdat;
    addr  = rand_bits(23);
    wdata = rand_bits(16);
    rdat  = rand_bits(16);
    word  = rdat[15:0];
    // strobes per lane, writes only drive hwr/lwr
    exp   = '{rd: is_read, hwr: !is_read && lanes[1], lwr: !is_read && lanes[0],
              addr: addr[22:0], wdata: wdata[15:0]};
    @(negedge clk);
    data_in = word;
    if (from_host) begin
      host = '{cs: 1'b1, we: !is_read, bs: lanes, adr: addr[22:0], wdat: wdata[15:0]};
    end else begin
      cpu = '{as_n: 1'b0, uds_n: !lanes[1], lds_n: !lanes[0], r_w: is_read,
              addr: addr[22:0], wdata: wdata[15:0]};
    end
  endtask

  task automatic release_master(input bit from_host);
    @(negedge clk);
    if (from_host) begin
      host.cs = 1'b0;
    end else begin
      cpu.as_n  = 1'b1;
      cpu.uds_n = 1'b1;
      cpu.lds_n = 1'b1;
    end
    @(negedge clk);
    check_bit("dtack_n", dtack_n, 1'b1);   // cleared by the latched as_n
    check_bit("host_ack", host_ack, 1'b0);
    repeat (8) @(negedge clk);             // let the fsm see the idle bus
  endtask

  task automatic finish_cycle(input bit from_host, input logic is_read,
                              input int_bus_t exp, input logic [15:0] word);
    bit acked;
    wait_dtack(acked);
    if (acked) begin
      if (from_host) check_bit("host_ack", host_ack, 1'b1);
      if (vpa) check_bit("eclk", eclk, 1'b1); // peripheral ack only in e high
      follow_strobe(exp);
      if (is_read && from_host) check_word("host_rdat", host_rdat, word);
      if (is_read && !from_host) check_word("rdata", rdata, word);
    end
    release_master(from_host);
  endtask

  task automatic bus_cycle(input bit from_host, input logic is_read, input logic [1:0] lanes);
    int_bus_t    exp;
    logic [15:0] word;
    drive_request(from_host, is_read, lanes, exp, word);
    finish_cycle(from_host, is_read, exp, word);
  endtask

  // --------------------
  // directed tests

  task automatic test_reset();
    @(negedge clk);
    check_bit("dtack_n", dtack_n, 1'b1);
    check_bit("bus strobes", bus.rd | bus.hwr | bus.lwr, 1'b0);
    check_bit("eclk", eclk, 1'b0);
    check_word("rdata", rdata, 16'h0000);
  endtask

  task automatic test_wait_states();
    int_bus_t    exp;
    logic [15:0] word;
    for (int s = 0; s < 2; s++) begin
      @(negedge clk);
      dbr  = (s == 0); // dma holds the bus
      dbs  = (s == 0);
      nrdy = (s == 1); // target not ready
      drive_request(1'b0, 1'b1, 2'b11, exp, word);
      repeat (40) begin
        @(negedge clk);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_bit("bus strobes", bus.rd | bus.hwr | bus.lwr, 1'b0);
      end
      dbr  = 1'b0;
      dbs  = 1'b0;
      nrdy = 1'b0;
      finish_cycle(1'b0, 1'b1, exp, word);
    end
  endtask

  task automatic test_host();
    @(negedge clk);
    cpu_halt = 1'b1;
    repeat (8) @(negedge clk);     // halt taken with the cpu idle
    bus_cycle(1'b1, 1'b1, 2'b11);
    bus_cycle(1'b1, 1'b0, 2'b01);
    cpu_halt = 1'b0;
    repeat (8) @(negedge clk);
    bus_cycle(1'b0, 1'b1, 2'b11);  // cpu owns the bus again
  endtask

  // --------------------
  // run

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    _as_and_cs = 1'b1;
    cpu        = REQ_IDLE;
    host       = '0;
    cpu_halt   = 1'b0;
    vpa        = 1'b0;
    dbr        = 1'b0;
    dbs        = 1'b0;
    nrdy       = 1'b0;
    data_in    = '0;
    repeat (8) @(negedge clk);
    _as_and_cs = 1'b0;

    test_reset();
    bus_cycle(1'b0, 1'b1, 2'b11);  // memory read
    bus_cycle(1'b0, 1'b0, 2'b10);  // upper lane write
    bus_cycle(1'b0, 1'b0, 2'b01);  // lower lane write
    bus_cycle(1'b0, 1'b0, 2'b11);  // word write
    test_wait_states();
    vpa = 1'b1;
    bus_cycle(1'b0, 1'b1, 2'b11);  // e clock peripheral read
    vpa = 1'b0;
    test_host();

    $display("checks %0d, value errors %0d, other failures %0d", checks, errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/cpu_bridge.sv
// 68000 to chipset bus bridge
module cpu_bridge (
  input  logic                 clk,
  input  logic                 _as_and_cs,
  input  bridge_pkg::cpu_req_t  cpu,
  input  bridge_pkg::host_req_t host,
  input  logic                 cpu_halt,
  input  logic                 vpa,
  input  logic                 dbr,
  input  logic                 dbs,
  input  logic                 nrdy,
  input  logic [15:0]          data_in,    // chipset read data
  output bridge_pkg::int_bus_t  bus,
  output logic                 dtack_n,
  output logic [15:0]          rdata,
  output logic                 eclk,
  output logic [15:0]          host_rdat,
  output logic                 host_ack
);
  import bridge_pkg::*;

  logic       clk7_en;
  logic       clk7n_en;
  logic       cck;
  logic [3:0] eclk_phase;
  logic       halt;
  logic       rdata_load;
  logic       rd;
  logic       hwr;
  logic       lwr;
  cpu_req_t   sel_req;  // before the request latch
  cpu_req_t   req;      // after it
  logic [15:0] rdata_q;

  // --------------------
  // timebase and master select

  eclk_timer u_timer (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .clk7_en    (clk7_en),
    .clk7n_en   (clk7n_en),
    .cck        (cck),
    .eclk_phase (eclk_phase),
    .eclk       (eclk)
  );

  host_arbiter u_arbiter (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .clk7_en    (clk7_en),
    .cpu        (cpu),
    .host       (host),
    .cpu_halt   (cpu_halt),
    .sel_req    (sel_req),
    .halt       (halt)
  );

  // request capture, every clk
  bus_latch #(.payload_t(cpu_req_t), .RESET_VAL(REQ_IDLE)) u_req_latch (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .load       (1'b1),
    .d          (sel_req),
    .q          (req)
  );

  // --------------------
  // cycle control and read data

  bus_cycle_fsm u_fsm (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .clk7_en    (clk7_en),
    .clk7n_en   (clk7n_en),
    .cck        (cck),
    .eclk_phase (eclk_phase),
    .req        (req),
    .vpa        (vpa),
    .dbr        (dbr),
    .dbs        (dbs),
    .nrdy       (nrdy),
    .dtack_n    (dtack_n),
    .rd         (rd),
    .hwr        (hwr),
    .lwr        (lwr),
    .rdata_load (rdata_load)
  );

  bus_latch #(.payload_t(logic [15:0])) u_rdata_latch (
    .clk        (clk),
    ._as_and_cs (_as_and_cs),
    .load       (rdata_load),
    .d          (data_in),
    .q          (rdata_q)
  );

  assign bus = '{rd: rd, hwr: hwr, lwr: lwr, addr: req.addr, wdata: req.wdata};

  assign rdata     = rdata_q;
  assign host_rdat = rdata_q;            // same latch serves both masters
  assign host_ack  = halt & ~dtack_n;    // only the host sees this one

endmodule

//--- src/bus_cycle_fsm.sv
// bus cycle state machine
module bus_cycle_fsm (
  input  logic                clk,
  input  logic                _as_and_cs,
  input  logic                clk7_en,
  input  logic                clk7n_en,
  input  logic                cck,
  input  logic [3:0]          eclk_phase,
  input  bridge_pkg::cpu_req_t req,        // latched request of the selected master
  input  logic                vpa,         // peripheral address decoded
  input  logic                dbr,         // chipset holds the data bus
  input  logic                dbs,         // slow target
  input  logic                nrdy,        // target not ready
  output logic                dtack_n,
  output logic                rd,
  output logic                hwr,
  output logic                lwr,
  output logic                rdata_load
);
  import bridge_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_grant, // waiting for a slot, then for clk7_en once dtack is down
    st_strobe,     // one 7 MHz cycle of rd or hwr/lwr
    st_hold        // transfer done, waiting for as_n release
  } state_t;

  state_t state;
  logic   l_as;    // as_n on the 7 MHz grid
  logic   lvpa;    // vpa on the 7 MHz grid
  logic   vma;     // valid memory address, synced to e clock
  logic   mem_ok;
  logic   per_ok;
  logic   grant;
  logic   ack_clr;

  // --------------------
  // 7 MHz samples and vma

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      l_as <= 1'b1;
      lvpa <= 1'b0;
      vma  <= 1'b0;
    end else if (clk7_en) begin
      l_as <= req.as_n;
      lvpa <= vpa;
      if (eclk_phase == VMA_CLR_PHASE) begin
        vma <= 1'b0; // e falls after this phase
      end else if (eclk_phase == VMA_SET_PHASE && lvpa) begin
        vma <= 1'b1;
      end
    end
  end

  // --------------------
  // slot grant and acknowledge

  assign mem_ok = !vpa && !(dbr && dbs);                         // no dma wait
  assign per_ok = vpa && vma && (eclk_phase == VMA_ACK_PHASE);   // cia window
  assign grant  = (state == st_wait_grant) && clk7n_en && cck && !nrdy
                  && (mem_ok || per_ok);

  // as_n rising ends the handshake without waiting for a clk edge
  assign ack_clr = _as_and_cs | req.as_n;

  always_ff @(posedge clk or posedge ack_clr) begin
    if (ack_clr) begin
      dtack_n <= 1'b1;
    end else if (grant) begin
      dtack_n <= 1'b0;
    end
  end

  // --------------------
  // cycle sequencing

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:       if (clk7_en && !l_as) state <= st_wait_grant;
        st_wait_grant: begin
          if (req.as_n) begin
            state <= st_idle; // master gave up
          end else if (clk7_en && !dtack_n) begin
            state <= st_strobe; // 2 clk after the grant
          end
        end
        st_strobe:     if (clk7_en) state <= st_hold; // exactly 4 clk
        st_hold:       if (l_as) state <= st_idle;
        default:       state <= st_idle;
      endcase
    end
  end

  // transfer strobes, lanes from the latched request
  assign rd  = (state == st_strobe) && req.r_w;
  assign hwr = (state == st_strobe) && !req.r_w && !req.uds_n;
  assign lwr = (state == st_strobe) && !req.r_w && !req.lds_n;

  // capture in the last clk of the read strobe
  assign rdata_load = (state == st_strobe) && clk7_en && req.r_w;

  // --------------------
  // checks

  a_rd_wr_excl: assert property (
    @(posedge clk) disable iff (_as_and_cs) !(rd && (hwr || lwr))
  );

  // a master must keep as_n low until its strobe has ended
  a_strobe_acked: assert property (
    @(posedge clk) disable iff (_as_and_cs) (rd || hwr || lwr) |-> !dtack_n
  );

endmodule

//--- src/host_arbiter.sv
// halt tracking and master select
module host_arbiter (
  input  logic                 clk,
  input  logic                 _as_and_cs,
  input  logic                 clk7_en,
  input  bridge_pkg::cpu_req_t  cpu,
  input  bridge_pkg::host_req_t host,
  input  logic                 cpu_halt,   // host wants the bus
  output bridge_pkg::cpu_req_t  sel_req,
  output logic                 halt
);

  // --------------------
  // halt, only changes with the cpu bus idle

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      halt <= 1'b0;
    end else if (clk7_en && cpu.as_n) begin
      halt <= cpu_halt; // set or clear between cpu cycles
    end
  end

  // --------------------
  // host request in cpu form

  always_comb begin
    if (halt) begin
      sel_req.as_n  = ~host.cs;
      sel_req.uds_n = ~host.bs[1];
      sel_req.lds_n = ~host.bs[0];
      sel_req.r_w   = ~host.we;   // write enable to read/write
      sel_req.addr  = host.adr;
      sel_req.wdata = host.wdat;
    end else begin
      sel_req = cpu;              // cpu owns the bus
    end
  end

endmodule

//--- src/bus_latch.sv
// payload register with load enable
module bus_latch #(
  parameter type      payload_t = logic [15:0],
  parameter payload_t RESET_VAL = '0          // value after reset
) (
  input  logic     clk,
  input  logic     _as_and_cs,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // --------------------
  // capture

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      q <= RESET_VAL;
    end else if (load) begin
      q <= d;    // hold otherwise
    end
  end

endmodule

//--- src/eclk_timer.sv
// 7 MHz and e clock timebase
module eclk_timer (
  input  logic       clk,
  input  logic       _as_and_cs,
  output logic       clk7_en,    // one clk in four
  output logic       clk7n_en,   // half a 7 MHz cycle later
  output logic       cck,        // colour clock phase
  output logic [3:0] eclk_phase, // 0..9
  output logic       eclk
);
  import bridge_pkg::*;

  logic [1:0] div; // clk / 4 divider

  // --------------------
  // 7 MHz enables

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      div <= '0;
    end else begin
      div <= div + 2'd1; // free running, wraps at 4
    end
  end

  assign clk7_en  = (div == CLK7_PHASE);
  assign clk7n_en = (div == CLK7N_PHASE);

  // --------------------
  // colour clock and e clock

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      cck        <= 1'b1; // high in even phases, so phase 8 is a cpu slot
      eclk_phase <= '0;
    end else if (clk7_en) begin
      cck <= ~cck; // dma and cpu slots alternate
      if (eclk_phase == ECLK_PHASES - 4'd1) begin
        eclk_phase <= '0;
      end else begin
        eclk_phase <= eclk_phase + 4'd1;
      end
    end
  end

  assign eclk = (eclk_phase >= ECLK_HIGH_FROM); // 6 low, 4 high

  // the vma and ack phase compares rely on the counter never leaving 0..9
  a_phase_range: assert property (
    @(posedge clk) disable iff (_as_and_cs) eclk_phase < ECLK_PHASES
  );

endmodule

//--- src/bridge_pkg.sv
// cpu bridge shared definitions
package bridge_pkg;

  // --------------------
  // bus structs

  // one bus master request, cpu or host mapped to cpu form
  typedef struct packed {
    logic        as_n;   // address strobe, active low
    logic        uds_n;  // upper byte lane d15..d8
    logic        lds_n;  // lower byte lane d7..d0
    logic        r_w;    // 1 = read
    logic [23:1] addr;   // word address
    logic [15:0] wdata;
  } cpu_req_t;

  // host port, active high controls
  typedef struct packed {
    logic        cs;
    logic        we;
    logic [1:0]  bs;     // [1] upper lane, [0] lower lane
    logic [23:1] adr;
    logic [15:0] wdat;
  } host_req_t;

  // chipset side of the bridge
  typedef struct packed {
    logic        rd;
    logic        hwr;
    logic        lwr;
    logic [23:1] addr;
    logic [15:0] wdata;
  } int_bus_t;

  // idle request, all strobes released
  localparam cpu_req_t REQ_IDLE = '{
    as_n:  1'b1,
    uds_n: 1'b1,
    lds_n: 1'b1,
    r_w:   1'b1,
    addr:  '0,
    wdata: '0
  };

  // --------------------
  // e clock, counted in 7 MHz cycles
  localparam logic [3:0] ECLK_PHASES    = 4'd10; // one e period
  localparam logic [3:0] ECLK_HIGH_FROM = 4'd6;  // low 0..5, high 6..9
  localparam logic [3:0] VMA_SET_PHASE  = 4'd3;  // latched vpa turns into vma here
  localparam logic [3:0] VMA_ACK_PHASE  = 4'd8;  // peripheral dtack window
  localparam logic [3:0] VMA_CLR_PHASE  = 4'd9;  // end of e high, vma drops

  // --------------------
  // enable phases within the four clk of one 7 MHz cycle
  localparam logic [1:0] CLK7_PHASE  = 2'd0;
  localparam logic [1:0] CLK7N_PHASE = 2'd2;

endpackage
